/* verification/spi_rx_cases.txt */
# op lane bits data expect; lane and bits decimal, data and expect hex
# frame: expect is the first word's entry, 0 for none; wr/rd: data is the address
# rd: bits is the expected pslverr; pop: bits entries; pair: data is {lane0, lane1}
# burst: expect is the number of frames, data counts up by one per frame
wr 0 0 04 00000001
frame 0 16 a5c3 1000a5c3
frame 0 16 0f1e 10010f1e
frame 0 16 8001 10028001
rd 0 0 08 00000300
pop 0 3 0 0
rd 0 0 08 00000001
end 0 0 0 0
frame 0 5 15 10030015
frame 0 21 17ddf3 1004beef
exp 0 0 0 10040013
frame 0 3 6 10050006
pop 0 4 0 0
end 0 0 0 0
wr 0 0 04 00000003
pair 0 16 11112222 0
exp 0 0 0 10061111
exp 1 0 0 20002222
pair 0 12 0abc0123 0
exp 0 0 0 10070abc
exp 1 0 0 20010123
pop 0 4 0 0
end 0 0 0 0
wr 0 0 04 00000001
frame 1 16 dead 0
frame 1 8 5a 0
rd 0 0 08 00000001
wr 0 0 04 00000003
frame 1 16 4321 20024321
pop 0 1 0 0
end 0 0 0 0
burst 0 16 c000 14
rd 0 0 0c 00000003
rd 0 0 08 00001000
end 0 0 0 0
wr 0 0 00 00000001
rd 0 0 08 00000001
rd 0 0 0c 00000000
rd 0 0 04 00000003
rd 0 1 10 00000000
frame 0 16 5a5a 10005a5a
pop 0 1 0 0
end 0 0 0 0

/* filelist.f */
+incdir+verilog
verilog/spi_rx_pkg.sv
verilog/apb_regs_pkg.sv
verilog/word_if.sv
verilog/spi_lane_rx.sv
verilog/word_fifo.sv
verilog/word_merger.sv
verilog/apb_spi_regs.sv
verilog/spi_rx_top.sv
verification/spi_rx_tb.sv

/* Bender.yml */
package:
  name: spi_rx

sources:
  - target: any(rtl, test)
    include_dirs:
      - verilog
    files:
      - verilog/spi_rx_pkg.sv
      - verilog/apb_regs_pkg.sv
      - verilog/word_if.sv
      - verilog/spi_lane_rx.sv
      - verilog/word_fifo.sv
      - verilog/word_merger.sv
      - verilog/apb_spi_regs.sv
      - verilog/spi_rx_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/spi_rx_tb.sv

/* verification/spi_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_cfg.svh"

module spi_rx_tb;

    logic        SCLK;
    logic        RST;
    logic        sdi0;
    logic        sen0;
    logic        sdi1;
    logic        sen1;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    string       op_q[$];
    int          lane_q[$];
    int          bits_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] lane0_exp[$];
    logic [31:0] lane1_exp[$];
    int          cycle_limit = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    spi_rx_top UUT (
        .SCLK(SCLK), .RST(RST), .sdi0(sdi0), .sen0(sen0), .sdi1(sdi1), .sen1(sen1),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        SCLK = 1'b0;
        forever #10 SCLK = ~SCLK;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        test_errors++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    // MSB first, then sen low and a random idle gap.
    task automatic shift_frame(input bit use0, input bit use1, input int nbits,
                               input logic [31:0] d0, input logic [31:0] d1);
        int i;
        int gap;
        for (i = nbits - 1; i >= 0; i--) begin
            @(negedge SCLK);
            if (use0) begin
                sen0 = 1'b1;
                sdi0 = d0[i];
            end
            if (use1) begin
                sen1 = 1'b1;
                sdi1 = d1[i];
            end
        end
        @(negedge SCLK);
        sen0 = 1'b0;
        sen1 = 1'b0;
        sdi0 = 1'b0;
        sdi1 = 1'b0;
        gap = 3 + ($urandom % 5);
        repeat (gap) @(negedge SCLK);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        @(negedge SCLK);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = wdata;
        @(negedge SCLK);
        penable = 1'b1;
        @(negedge SCLK);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // sampled at the rising edge that ends the access phase.
    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        @(negedge SCLK);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge SCLK);
        penable = 1'b1;
        @(posedge SCLK);
        rdata = prdata;
        err = pslverr;
        check_value({31'b0, pready}, 32'h1, "pready");
        @(negedge SCLK);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic push_expected(input int lane, input logic [31:0] entry);
        if (lane == 0) begin
            lane0_exp.push_back(entry);
        end else begin
            lane1_exp.push_back(entry);
        end
    endtask

    // cross-lane order is free, each lane keeps its own order.
    task automatic pop_entries(input int count);
        logic [31:0] rdata;
        logic        err;
        int          n;
        int          polls;
        for (n = 0; n < count; n++) begin
            rdata = 32'h1;
            polls = 0;
            while (rdata[0] && polls < 20) begin
                apb_read(apb_regs_pkg::STATUS, rdata, err);
                polls++;
            end
            if (rdata[0]) begin
                report_problem("FIFO stayed empty while a word was expected");
            end else begin
                apb_read(apb_regs_pkg::DATA, rdata, err);
                check_value({31'b0, err}, 32'h0, "pslverr of DATA");
                if (rdata[31:28] == `SPI_RX_LANE0_ID && lane0_exp.size() > 0) begin
                    check_value(rdata, lane0_exp.pop_front(), "lane 0 entry");
                end else if (rdata[31:28] == `SPI_RX_LANE1_ID && lane1_exp.size() > 0) begin
                    check_value(rdata, lane1_exp.pop_front(), "lane 1 entry");
                end else begin
                    report_problem($sformatf("FIFO returned unexpected entry %h", rdata));
                end
            end
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (lane0_exp.size() + lane1_exp.size() != 0) begin
            report_problem($sformatf("%0d expected words never left the FIFO",
                                     lane0_exp.size() + lane1_exp.size()));
            lane0_exp.delete();
            lane1_exp.delete();
        end
        if (test_errors == 0) begin
            $display("test %0d passed", tests_run);
        end else begin
            $display("test %0d failed with %0d errors", tests_run, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic run_case(input int k);
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  addr;
        int          n;
        addr = data_q[k][7:0];
        if (op_q[k] == "wr") begin
            apb_write(addr, exp_q[k]);
        end else if (op_q[k] == "rd") begin
            apb_read(addr, rdata, err);
            check_value(rdata, exp_q[k], $sformatf("register %h", addr));
            check_value({31'b0, err}, bits_q[k], $sformatf("pslverr of register %h", addr));
        end else if (op_q[k] == "frame") begin
            if (exp_q[k] != 0) begin
                push_expected(lane_q[k], exp_q[k]);
            end
            shift_frame(lane_q[k] == 0, lane_q[k] == 1, bits_q[k], data_q[k], data_q[k]);
        end else if (op_q[k] == "pair") begin
            shift_frame(1'b1, 1'b1, bits_q[k], {16'h0, data_q[k][31:16]},
                        {16'h0, data_q[k][15:0]});
        end else if (op_q[k] == "burst") begin
            for (n = 0; n < exp_q[k]; n++) begin
                shift_frame(lane_q[k] == 0, lane_q[k] == 1, bits_q[k], data_q[k] + n,
                            data_q[k] + n);
            end
        end else if (op_q[k] == "exp") begin
            push_expected(lane_q[k], exp_q[k]);
        end else if (op_q[k] == "pop") begin
            pop_entries(bits_q[k]);
        end else if (op_q[k] == "end") begin
            finish_test();
        end else begin
            report_problem($sformatf("case file holds unknown operation %s", op_q[k]));
        end
    endtask

    task automatic load_cases(output bit loaded);
        int          fd;
        int          n;
        int          lane;
        int          nbits;
        int          budget;
        logic [31:0] dval;
        logic [31:0] expv;
        string       line;
        string       op;
        budget = 216;
        fd = $fopen("verification/spi_rx_cases.txt", "r");
        loaded = (fd != 0);
        if (loaded) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %d %h %h", op, lane, nbits, dval, expv);
                    if (n == 5) begin
                        op_q.push_back(op);
                        lane_q.push_back(lane);
                        bits_q.push_back(nbits);
                        data_q.push_back(dval);
                        exp_q.push_back(expv);
                        budget += 40;
                        if (op == "frame" || op == "pair") begin
                            budget += nbits + 12;
                        end else if (op == "burst") begin
                            budget += (nbits + 12) * expv;
                        end else if (op == "pop") begin
                            budget += 20 * nbits;
                        end
                    end
                end
            end
            $fclose(fd);
            cycle_limit = budget;
        end
    endtask

    initial begin
        wait (cycle_limit > 0);
        #(cycle_limit * 20);
        $display("watchdog expired after %0d cycles, the run did not complete", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        bit          loaded;
        int unsigned seed_draw;
        int          k;
        RST = 1'b1;
        sdi0 = 1'b0;
        sen0 = 1'b0;
        sdi1 = 1'b0;
        sen1 = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed_draw = $urandom(32'h2e33_92f4);
        load_cases(loaded);
        if (!loaded) begin
            $display("case file verification/spi_rx_cases.txt could not be opened");
        end else begin
            repeat (16) @(negedge SCLK);
            RST = 1'b0;
            for (k = 0; k < op_q.size(); k++) begin
                run_case(k);
            end
            repeat (4) @(negedge SCLK);
        end
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (loaded && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/spi_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_cfg.svh"

module spi_rx_top (
    input  logic                               SCLK,
    input  logic                               RST,
    input  logic                               sdi0,
    input  logic                               sen0,
    input  logic                               sdi1,
    input  logic                               sen1,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [apb_regs_pkg::ADDR_BITS-1:0] paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr
);

    localparam int LEVEL_BITS = $clog2(`SPI_RX_FIFO_DEPTH) + 1;

    logic                         en0;
    logic                         en1;
    logic                         soft_clear;
    logic [`SPI_RX_LOST_BITS-1:0] lost0;
    logic [`SPI_RX_LOST_BITS-1:0] lost1;
    logic [LEVEL_BITS-1:0]        level;

    word_if lane0_w ();
    word_if lane1_w ();
    word_if fifo_w ();

    spi_lane_rx #(.LANE_ID(`SPI_RX_LANE0_ID)) u_lane0 (
        .SCLK(SCLK), .RST(RST), .sdi(sdi0), .sen(sen0),
        .enable(en0), .clear(soft_clear), .lost(lost0), .w(lane0_w)
    );

    spi_lane_rx #(.LANE_ID(`SPI_RX_LANE1_ID)) u_lane1 (
        .SCLK(SCLK), .RST(RST), .sdi(sdi1), .sen(sen1),
        .enable(en1), .clear(soft_clear), .lost(lost1), .w(lane1_w)
    );

    word_merger u_merger (
        .SCLK(SCLK), .RST(RST), .clear(soft_clear),
        .lane0(lane0_w), .lane1(lane1_w), .out(fifo_w), .level(level)
    );

    apb_spi_regs #(.LEVEL_BITS(LEVEL_BITS)) u_regs (
        .SCLK(SCLK), .RST(RST),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .lost0(lost0), .lost1(lost1), .level(level), .fifo(fifo_w),
        .en0(en0), .en1(en1), .clear(soft_clear)
    );

endmodule

`default_nettype wire

/* verilog/apb_spi_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_spi_regs #(
    parameter int LEVEL_BITS = 5
) (
    input  logic                               SCLK,
    input  logic                               RST,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [apb_regs_pkg::ADDR_BITS-1:0] paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic [7:0]                         lost0,
    input  logic [7:0]                         lost1,
    input  logic [LEVEL_BITS-1:0]              level,
    word_if.snk                                fifo,
    output logic                               en0,
    output logic                               en1,
    output logic                               clear
);

    apb_regs_pkg::reg_addr_e addr;
    logic                    access;
    logic                    wr_acc;
    logic                    data_rd;

    assign addr    = apb_regs_pkg::reg_addr_e'(paddr);
    assign access  = psel && penable;
    assign wr_acc  = access && pwrite;
    assign data_rd = access && !pwrite && (addr == apb_regs_pkg::DATA);

    // no wait states.
    assign pready = 1'b1;

    // head entry leaves at the end of the DATA read.
    assign fifo.ready = data_rd && fifo.valid;
    assign pslverr    = data_rd && !fifo.valid;

    always_ff @(posedge SCLK) begin
        if (RST) begin
            en0 <= 1'b0;
            en1 <= 1'b0;
        end else if (wr_acc && (addr == apb_regs_pkg::CTRL)) begin
            en0 <= pwdata[apb_regs_pkg::CTRL_EN0_BIT];
            en1 <= pwdata[apb_regs_pkg::CTRL_EN1_BIT];
        end
    end

    always_ff @(posedge SCLK) begin
        if (RST) begin
            clear <= 1'b0;
        end else begin
            clear <= wr_acc && (addr == apb_regs_pkg::CLEAR);
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (addr)
                apb_regs_pkg::CTRL: begin
                    prdata[apb_regs_pkg::CTRL_EN0_BIT] = en0;
                    prdata[apb_regs_pkg::CTRL_EN1_BIT] = en1;
                end
                apb_regs_pkg::STATUS: begin
                    prdata[0]               = !fifo.valid;
                    prdata[8 +: LEVEL_BITS] = level;
                end
                apb_regs_pkg::LOST: begin
                    prdata[7:0]  = lost0;
                    prdata[15:8] = lost1;
                end
                apb_regs_pkg::DATA: begin
                    // empty read returns zero.
                    if (fifo.valid) begin
                        prdata = {fifo.id, fifo.frame, fifo.data};
                    end
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/word_merger.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_cfg.svh"

module word_merger (
    input  logic                                SCLK,
    input  logic                                RST,
    input  logic                                clear,
    word_if.snk                                 lane0,
    word_if.snk                                 lane1,
    word_if.src                                 out,
    output logic [$clog2(`SPI_RX_FIFO_DEPTH):0] level
);

    logic                 full;
    logic                 prio1;
    logic                 gnt0;
    logic                 gnt1;
    logic                 wr;
    spi_rx_pkg::lane_id_t wr_id;
    spi_rx_pkg::frame_t   wr_frame;
    spi_rx_pkg::payload_t wr_data;

    // prio1 set means lane 1 wins a tie.
    assign gnt0 = !full && lane0.valid && (!lane1.valid || !prio1);
    assign gnt1 = !full && lane1.valid && !gnt0;
    assign wr   = gnt0 || gnt1;

    assign lane0.ready = gnt0;
    assign lane1.ready = gnt1;

    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            prio1 <= 1'b0;
        end else if (wr) begin
            prio1 <= gnt0;
        end
    end

    always_comb begin
        if (gnt1) begin
            wr_id    = lane1.id;
            wr_frame = lane1.frame;
            wr_data  = lane1.data;
        end else begin
            wr_id    = lane0.id;
            wr_frame = lane0.frame;
            wr_data  = lane0.data;
        end
    end

    word_fifo u_fifo (
        .SCLK     (SCLK),
        .RST      (RST),
        .clear    (clear),
        .wr       (wr),
        .wr_id    (wr_id),
        .wr_frame (wr_frame),
        .wr_data  (wr_data),
        .full     (full),
        .level    (level),
        .rd       (out)
    );

    // a lane passed over while valid wins the next free slot.
    a_round_robin: assert property (
        @(posedge SCLK) disable iff (RST || clear)
        (wr && lane0.valid && lane1.valid) |=> (full || (gnt0 != $past(gnt0)))
    );

endmodule

`default_nettype wire

/* verilog/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_cfg.svh"

module word_fifo (
    input  logic                                SCLK,
    input  logic                                RST,
    input  logic                                clear,
    input  logic                                wr,
    input  spi_rx_pkg::lane_id_t                wr_id,
    input  spi_rx_pkg::frame_t                  wr_frame,
    input  spi_rx_pkg::payload_t                wr_data,
    output logic                                full,
    output logic [$clog2(`SPI_RX_FIFO_DEPTH):0] level,
    word_if.src                                 rd
);

    localparam int DEPTH      = `SPI_RX_FIFO_DEPTH;
    localparam int AW         = $clog2(DEPTH);
    localparam int ENTRY_BITS = $bits(spi_rx_pkg::lane_id_t) + $bits(spi_rx_pkg::frame_t)
                                + `SPI_RX_WORD_BITS;

    logic [ENTRY_BITS-1:0] mem [DEPTH];
    logic [AW:0]           wr_ptr;
    logic [AW:0]           rd_ptr;
    logic                  pop;

    // extra pointer bit tells full from empty.
    assign level = wr_ptr - rd_ptr;
    assign full  = (level == (AW+1)'(DEPTH));
    assign pop   = rd.valid && rd.ready;

    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge SCLK) begin
        if (wr && !full) begin
            mem[wr_ptr[AW-1:0]] <= {wr_id, wr_frame, wr_data};
        end
    end

    assign rd.valid = (level != '0);
    assign {rd.id, rd.frame, rd.data} = mem[rd_ptr[AW-1:0]];

    a_no_write_full: assert property (
        @(posedge SCLK) disable iff (RST || clear)
        !(wr && full)
    );

endmodule

`default_nettype wire

/* verilog/spi_lane_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_lane_rx #(
    parameter spi_rx_pkg::lane_id_t LANE_ID = 4'd1
) (
    input  logic       SCLK,
    input  logic       RST,
    input  logic       sdi,
    input  logic       sen,
    input  logic       enable,
    input  logic       clear,
    output logic [7:0] lost,
    word_if.src        w
);

    localparam int WORD_BITS = $bits(spi_rx_pkg::payload_t);
    localparam int CNT_BITS  = $clog2(WORD_BITS);

    spi_rx_pkg::lane_state_e state;
    spi_rx_pkg::payload_t    shift_q;
    spi_rx_pkg::payload_t    word;
    spi_rx_pkg::payload_t    hold_data;
    spi_rx_pkg::frame_t      frame_cnt;
    spi_rx_pkg::frame_t      hold_frame;
    logic [CNT_BITS-1:0]     bit_cnt;
    logic                    sen_dly;
    logic                    sen_fall;
    logic                    sample;
    logic                    last_bit;
    logic                    word_done;
    logic                    hold_free;

    assign sen_fall = sen_dly && !sen;
    assign sample   = sen && enable;
    assign last_bit = sample && (bit_cnt == CNT_BITS'(WORD_BITS - 1));
    // a frame ending with bits pending closes a short word.
    assign word_done = last_bit || (sen_fall && enable && (bit_cnt != '0));
    assign word      = last_bit ? {shift_q[WORD_BITS-2:0], sdi} : shift_q;
    assign hold_free = (state != spi_rx_pkg::HOLD) || w.ready;

    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            sen_dly   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            sen_dly <= sen;
            if (sen_fall && enable) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // zeroed after each word so short words come out right-aligned.
    always_ff @(posedge SCLK) begin
        if (RST || clear || !enable || word_done) begin
            bit_cnt <= '0;
            shift_q <= '0;
        end else if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            shift_q <= {shift_q[WORD_BITS-2:0], sdi};
        end
    end

    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            state <= spi_rx_pkg::IDLE;
        end else if (word_done && hold_free) begin
            state <= spi_rx_pkg::HOLD;
        end else if (hold_free) begin
            state <= sample ? spi_rx_pkg::SHIFT : spi_rx_pkg::IDLE;
        end
    end

    always_ff @(posedge SCLK) begin
        if (word_done && hold_free) begin
            hold_data  <= word;
            hold_frame <= frame_cnt;
        end
    end

    // hold still busy, the new word is dropped.
    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            lost <= '0;
        end else if (word_done && !hold_free && (lost != '1)) begin
            lost <= lost + 1'b1;
        end
    end

    assign w.valid = (state == spi_rx_pkg::HOLD);
    assign w.id    = LANE_ID;
    assign w.frame = hold_frame;
    assign w.data  = hold_data;

    a_hold_stable: assert property (
        @(posedge SCLK) disable iff (RST || clear)
        (w.valid && !w.ready) |=> (w.valid && $stable(w.frame) && $stable(w.data))
    );

endmodule

`default_nettype wire

/* verilog/word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface word_if;

    logic                 valid;
    logic                 ready;
    spi_rx_pkg::lane_id_t id;
    spi_rx_pkg::frame_t   frame;
    spi_rx_pkg::payload_t data;

    // source holds valid and fields until ready.
    modport src (output valid, output id, output frame, output data, input ready);
    modport snk (input valid, input id, input frame, input data, output ready);

endinterface

`default_nettype wire

/* verilog/apb_regs_pkg.sv */
`default_nettype none

package apb_regs_pkg;

    localparam int ADDR_BITS = 8;

    // register offsets.
    typedef enum logic [ADDR_BITS-1:0] {
        CLEAR  = 8'h00,
        CTRL   = 8'h04,
        STATUS = 8'h08,
        LOST   = 8'h0C,
        DATA   = 8'h10
    } reg_addr_e;

    // lane enables in CTRL.
    localparam int CTRL_EN0_BIT = 0;
    localparam int CTRL_EN1_BIT = 1;

endpackage

`default_nettype wire

/* verilog/spi_rx_pkg.sv */
`default_nettype none

package spi_rx_pkg;

    // tag fields of one captured word.
    typedef logic [3:0]  lane_id_t;
    typedef logic [11:0] frame_t;
    typedef logic [15:0] payload_t;

    // hold register state of a lane.
    // SHIFT means a frame is active with the hold register free.
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        HOLD
    } lane_state_e;

endpackage

`default_nettype wire

/* verilog/spi_rx_cfg.svh */
`ifndef SPI_RX_CFG_SVH
`define SPI_RX_CFG_SVH

// word entries in the shared FIFO, power of two.
`define SPI_RX_FIFO_DEPTH 16

// lane identifiers placed in bits 31:28 of a FIFO entry.
`define SPI_RX_LANE0_ID 4'd1
`define SPI_RX_LANE1_ID 4'd2

// payload bits per captured word.
`define SPI_RX_WORD_BITS 16

// width of each saturating lost-word counter.
`define SPI_RX_LOST_BITS 8

`endif
